// ==== Makefile ====
# Verilator simulation of the host-to-card receive path
# a run passes only when the log holds the pass line of the testbench

TOP := tb_h2c_rx_path
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, then search $(LOG) for TEST OK"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f src.f
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== src.f ====
src/h2c_pkg.sv
src/reset_sync.sv
src/async_fifo.sv
src/gb_64to32.sv
src/rx_frame_stats.sv
src/h2c_rx_path.sv
tests/tb_clkgen.sv
tests/h2c_rx_path_assert.sv
tests/tb_h2c_rx_path.sv

// ==== src/async_fifo.sv ====
/*
 * async_fifo
 * dual-clock FIFO, one beat plus last bit per entry
 * binary and gray pointers, two-flop pointer synchronizers
 * full on the write side, empty on the read side
 */

module async_fifo
    import h2c_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    // write side
    input  logic                   clk_w,
    input  logic                   rst_w_n,
    input  logic                   wr,
    input  logic [dma_bus_nbits:0] din,
    output logic                   full,
    // read side
    input  logic                   clk_r,
    input  logic                   rst_r_n,
    input  logic                   rd,
    output logic [dma_bus_nbits:0] dout,
    output logic                   empty
);

    localparam int depth = 2 ** FIFO_DEPTH_LOG2;

    // gray distance of a full fifo, top two bits differ
    localparam logic [FIFO_DEPTH_LOG2:0] full_mask =
        {2'b11, {(FIFO_DEPTH_LOG2-1){1'b0}}};

    // storage
    logic [dma_bus_nbits:0] mem [depth];

    // write domain pointers
    logic [FIFO_DEPTH_LOG2:0] wbin;
    logic [FIFO_DEPTH_LOG2:0] wbin_next;
    logic [FIFO_DEPTH_LOG2:0] wgray;
    logic [FIFO_DEPTH_LOG2:0] rgray_w1;
    logic [FIFO_DEPTH_LOG2:0] rgray_w2;
    logic                     wr_en;

    // read domain pointers
    logic [FIFO_DEPTH_LOG2:0] rbin;
    logic [FIFO_DEPTH_LOG2:0] rbin_next;
    logic [FIFO_DEPTH_LOG2:0] rgray;
    logic [FIFO_DEPTH_LOG2:0] wgray_r1;
    logic [FIFO_DEPTH_LOG2:0] wgray_r2;
    logic                     rd_en;

    ////////////////////////////////////////////////////////////////////
    // write domain
    ////////////////////////////////////////////////////////////////////

    // writes while full are dropped
    assign wr_en     = wr & ~full;
    assign wbin_next = wbin + 1'b1;

    always_ff @(posedge clk_w) begin
        if (!rst_w_n) begin
            wbin  <= '0;
            wgray <= '0;
        end else if (wr_en) begin
            wbin  <= wbin_next;
            wgray <= wbin_next ^ (wbin_next >> 1);
        end
    end

    // no reset on the array
    always_ff @(posedge clk_w) begin
        if (wr_en) begin
            mem[wbin[FIFO_DEPTH_LOG2-1:0]] <= din;
        end
    end

    // read pointer into write domain
    always_ff @(posedge clk_w) begin
        if (!rst_w_n) begin
            rgray_w1 <= '0;
            rgray_w2 <= '0;
        end else begin
            rgray_w1 <= rgray;
            rgray_w2 <= rgray_w1;
        end
    end

    // full when pointers are one lap apart
    assign full = ((wgray ^ rgray_w2) == full_mask);

    ////////////////////////////////////////////////////////////////////
    // read domain
    ////////////////////////////////////////////////////////////////////

    // reads while empty are dropped
    assign rd_en     = rd & ~empty;
    assign rbin_next = rbin + 1'b1;

    always_ff @(posedge clk_r) begin
        if (!rst_r_n) begin
            rbin  <= '0;
            rgray <= '0;
        end else if (rd_en) begin
            rbin  <= rbin_next;
            rgray <= rbin_next ^ (rbin_next >> 1);
        end
    end

    // write pointer into read domain
    always_ff @(posedge clk_r) begin
        if (!rst_r_n) begin
            wgray_r1 <= '0;
            wgray_r2 <= '0;
        end else begin
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
        end
    end

    assign empty = (rgray == wgray_r2);

    // head of queue shows without a read, pop moves on
    assign dout = mem[rbin[FIFO_DEPTH_LOG2-1:0]];

endmodule

// ==== src/gb_64to32.sv ====
/*
 * gb_64to32
 * dma beats into the async FIFO on clk_axi
 * upper then lower 32-bit word out on clk_mac, no back-pressure
 * per-domain reset synchronizers
 */

module gb_64to32
    import h2c_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input  logic                     clk_mac,
    input  logic                     clk_axi,
    input  logic                     rst_n,
    // dma side, clk_axi
    input  logic                     m_axis_h2c_tvalid,
    input  logic                     m_axis_h2c_tlast,
    input  logic [dma_bus_nbits-1:0] m_axis_h2c_tdata,
    output logic                     m_axis_h2c_tready,
    // mac side, clk_mac
    output logic [pbus_nbits-1:0]    rx_axis_tdata,
    output logic                     rx_axis_tvalid,
    output logic                     rx_axis_tlast
);

    // beat plus last bit
    localparam int fifo_nbits = $bits(h2c_beat_u) + 1;

    logic rst_mac_n;
    logic rst_axi_n;

    logic                  fifo_wr;
    logic                  fifo_full;
    logic                  fifo_rd;
    logic                  fifo_empty;
    logic [fifo_nbits-1:0] fifo_din;
    logic [fifo_nbits-1:0] fifo_dout;

    h2c_beat_u wr_beat;
    h2c_beat_u rd_beat;
    logic      rd_last;

    // 0 sends hi lane next, 1 sends lo lane and pops
    logic lo_phase;

    ////////////////////////////////////////////////////////////////////
    // resets and fifo
    ////////////////////////////////////////////////////////////////////

    reset_sync u_rst_mac (
        .clk        (clk_mac),
        .rst_n      (rst_n),
        .rst_n_sync (rst_mac_n)
    );

    reset_sync u_rst_axi (
        .clk        (clk_axi),
        .rst_n      (rst_n),
        .rst_n_sync (rst_axi_n)
    );

    // accept whenever there is room
    assign m_axis_h2c_tready = ~fifo_full;
    assign fifo_wr           = m_axis_h2c_tvalid & m_axis_h2c_tready;

    assign wr_beat.beat = m_axis_h2c_tdata;
    assign fifo_din     = {wr_beat, m_axis_h2c_tlast};

    async_fifo #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_fifo (
        .clk_w   (clk_axi),
        .rst_w_n (rst_axi_n),
        .wr      (fifo_wr),
        .din     (fifo_din),
        .full    (fifo_full),
        .clk_r   (clk_mac),
        .rst_r_n (rst_mac_n),
        .rd      (fifo_rd),
        .dout    (fifo_dout),
        .empty   (fifo_empty)
    );

    assign {rd_beat, rd_last} = fifo_dout;

    ////////////////////////////////////////////////////////////////////
    // mac side split
    ////////////////////////////////////////////////////////////////////

    // head leaves the fifo with its lo lane
    assign fifo_rd = ~fifo_empty & lo_phase;

    always_ff @(posedge clk_mac) begin
        if (!rst_mac_n) begin
            lo_phase       <= 1'b0;
            rx_axis_tvalid <= 1'b0;
            rx_axis_tlast  <= 1'b0;
        end else begin
            rx_axis_tvalid <= ~fifo_empty;
            // frame end only on the lower word
            rx_axis_tlast  <= fifo_rd & rd_last;
            if (!fifo_empty) begin
                lo_phase <= ~lo_phase;
            end
        end
    end

    // word payload, held while idle
    always_ff @(posedge clk_mac) begin
        if (!fifo_empty) begin
            rx_axis_tdata <= lo_phase ? rd_beat.lanes[lane_lo] : rd_beat.lanes[lane_hi];
        end
    end

endmodule

// ==== src/h2c_pkg.sv ====
/*
 * shared widths of the host-to-card receive path
 * beat union for one FIFO word, read whole or as two MAC lanes
 */

package h2c_pkg;

    // dma side beat width
    localparam int dma_bus_nbits = 64;

    // mac side word width
    localparam int pbus_nbits = 32;

    // mac words carried by one dma beat
    localparam int lanes_per_beat = dma_bus_nbits / pbus_nbits;

    // lane indices inside a beat, upper half goes out first
    localparam int lane_hi = 1;
    localparam int lane_lo = 0;

    // one fifo word without its last bit
    // beat  : as written by the dma side
    // lanes : as split by the gearbox
    typedef union packed {
        logic [dma_bus_nbits-1:0] beat;
        logic [lanes_per_beat-1:0][pbus_nbits-1:0] lanes;
    } h2c_beat_u;

endpackage

// ==== src/h2c_rx_path.sv ====
/*
 * h2c_rx_path
 * host-to-card receive path top level
 * 64-to-32 gearbox with its async FIFO, plus output statistics
 */

module h2c_rx_path
    import h2c_pkg::*;
#(
    parameter int FIFO_DEPTH_LOG2 = 3,
    parameter int STATS_NBITS     = 16
) (
    input  logic                     clk_mac,
    input  logic                     clk_axi,
    input  logic                     rst_n,
    // dma side, clk_axi
    input  logic                     m_axis_h2c_tvalid,
    input  logic                     m_axis_h2c_tlast,
    input  logic [dma_bus_nbits-1:0] m_axis_h2c_tdata,
    output logic                     m_axis_h2c_tready,
    // mac side, clk_mac
    output logic [pbus_nbits-1:0]    rx_axis_tdata,
    output logic                     rx_axis_tvalid,
    output logic                     rx_axis_tlast,
    // statistics, clk_mac
    output logic [STATS_NBITS-1:0]   word_count,
    output logic [STATS_NBITS-1:0]   frame_count
);

    // clock crossing and width split
    gb_64to32 #(
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) u_gb (
        .clk_mac           (clk_mac),
        .clk_axi           (clk_axi),
        .rst_n             (rst_n),
        .m_axis_h2c_tvalid (m_axis_h2c_tvalid),
        .m_axis_h2c_tlast  (m_axis_h2c_tlast),
        .m_axis_h2c_tdata  (m_axis_h2c_tdata),
        .m_axis_h2c_tready (m_axis_h2c_tready),
        .rx_axis_tdata     (rx_axis_tdata),
        .rx_axis_tvalid    (rx_axis_tvalid),
        .rx_axis_tlast     (rx_axis_tlast)
    );

    // watches the same stream the mac gets
    rx_frame_stats #(
        .STATS_NBITS (STATS_NBITS)
    ) u_stats (
        .clk_mac        (clk_mac),
        .rst_n          (rst_n),
        .rx_axis_tvalid (rx_axis_tvalid),
        .rx_axis_tlast  (rx_axis_tlast),
        .word_count     (word_count),
        .frame_count    (frame_count)
    );

endmodule

// ==== src/reset_sync.sv ====
/*
 * reset_sync
 * two-flop release alignment of rst_n into one clock domain
 */

module reset_sync (
    input  logic clk,
    input  logic rst_n,
    output logic rst_n_sync
);

    // shift chain, all zero while rst_n is low
    logic [1:0] sync_q;

    // ones shift in after release
    // so the domain leaves reset two edges later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // last stage drives the domain reset
    assign rst_n_sync = sync_q[1];

endmodule

// ==== src/rx_frame_stats.sv ====
/*
 * rx_frame_stats
 * word and frame counters on the outgoing mac stream
 */

module rx_frame_stats #(
    parameter int STATS_NBITS = 16
) (
    input  logic                   clk_mac,
    input  logic                   rst_n,
    input  logic                   rx_axis_tvalid,
    input  logic                   rx_axis_tlast,
    output logic [STATS_NBITS-1:0] word_count,
    output logic [STATS_NBITS-1:0] frame_count
);

    // one frame ends per valid word with last
    logic frame_end;

    assign frame_end = rx_axis_tvalid & rx_axis_tlast;

    ////////////////////////////////////////////////////////////////////
    // counters
    ////////////////////////////////////////////////////////////////////

    // every valid word, wraps at full width
    always_ff @(posedge clk_mac) begin
        if (!rst_n) begin
            word_count <= '0;
        end else if (rx_axis_tvalid) begin
            word_count <= word_count + 1'b1;
        end
    end

    // completed frames, wraps the same way
    always_ff @(posedge clk_mac) begin
        if (!rst_n) begin
            frame_count <= '0;
        end else if (frame_end) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    // both counts lag the word by one clk_mac cycle
    // rst_n taken straight from the top level, held long enough

endmodule

// ==== tests/h2c_rx_path_assert.sv ====
/*
 * concurrent checks inside the gearbox, bound into gb_64to32
 * last only with valid, no FIFO write while full, hi/lo word pairing
 */

module h2c_rx_path_assert #(
    parameter int FIFO_DEPTH_LOG2 = 3
) (
    input logic clk_mac,
    input logic clk_axi,
    input logic rst_mac_n,
    input logic rst_axi_n,
    input logic fifo_wr,
    input logic fifo_rd,
    input logic rx_axis_tvalid,
    input logic rx_axis_tlast,
    input logic lo_phase
);

    localparam int depth = 2 ** FIFO_DEPTH_LOG2;

    // beats pushed and popped since reset
    // their difference is the true fill level
    int wr_total;
    int rd_total;

    // failed checks per clock domain, summed by the testbench top
    int mac_fails = 0;
    int axi_fails = 0;

    always_ff @(posedge clk_axi) begin
        if (!rst_axi_n) begin
            wr_total <= 0;
        end else if (fifo_wr) begin
            wr_total <= wr_total + 1;
        end
    end

    always_ff @(posedge clk_mac) begin
        if (!rst_mac_n) begin
            rd_total <= 0;
        end else if (fifo_rd) begin
            rd_total <= rd_total + 1;
        end
    end

    // lo_phase high after an edge means the word just sent was the hi lane

    last_needs_valid: assert property (
        @(posedge clk_mac) disable iff (!rst_mac_n)
        rx_axis_tlast |-> rx_axis_tvalid
    ) else begin
        mac_fails++;
        $error("rx_axis_tlast high without rx_axis_tvalid");
    end

    // write side, a write needs a free entry
    no_write_when_full: assert property (
        @(posedge clk_axi) disable iff (!rst_axi_n)
        fifo_wr |-> ((wr_total - rd_total) < depth)
    ) else begin
        axi_fails++;
        $error("FIFO write accepted while full");
    end

    // hi word always followed by its lo word
    hi_then_lo: assert property (
        @(posedge clk_mac) disable iff (!rst_mac_n)
        (rx_axis_tvalid && lo_phase) |=> (rx_axis_tvalid && !lo_phase)
    ) else begin
        mac_fails++;
        $error("upper word not followed by lower word");
    end

    // lo word only right after a hi word
    lo_after_hi: assert property (
        @(posedge clk_mac) disable iff (!rst_mac_n)
        (rx_axis_tvalid && !lo_phase) |-> $past(rx_axis_tvalid && lo_phase)
    ) else begin
        mac_fails++;
        $error("lower word without upper word before it");
    end

endmodule

bind gb_64to32 h2c_rx_path_assert #(
    .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
) u_gb_assert (
    .clk_mac        (clk_mac),
    .clk_axi        (clk_axi),
    .rst_mac_n      (rst_mac_n),
    .rst_axi_n      (rst_axi_n),
    .fifo_wr        (fifo_wr),
    .fifo_rd        (fifo_rd),
    .rx_axis_tvalid (rx_axis_tvalid),
    .rx_axis_tlast  (rx_axis_tlast),
    .lo_phase       (lo_phase)
);

// ==== tests/tb_clkgen.sv ====
/*
 * testbench clocks and reset
 * clk_mac period 10, clk_axi period 14, rst_n low for 8 clk_mac cycles
 */

module tb_clkgen (
    output logic clk_mac,
    output logic clk_axi,
    output logic rst_n
);

    initial begin
        clk_mac = 1'b0;
        forever #5 clk_mac = ~clk_mac;
    end

    // slower dma clock, edges drift against clk_mac
    initial begin
        clk_axi = 1'b0;
        forever #7 clk_axi = ~clk_axi;
    end

    // release just after a clk_mac edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk_mac);
        #1;
        rst_n = 1'b1;
    end

endmodule

// ==== tests/tb_h2c_rx_path.sv ====
/*
 * testbench of the host-to-card receive path
 * lcg beat data, reference split into expected words, compare process
 * watchdog and closing report
 */

module tb_h2c_rx_path
    import h2c_pkg::*;
();

    // worst case beats over all tests, sets the watchdog
    localparam int max_beats       = 1 + 12 * 6 + 48 + 8 * 6;
    localparam int watchdog_cycles = max_beats * 40 + 400;

    logic                     clk_mac;
    logic                     clk_axi;
    logic                     rst_n;
    logic                     m_axis_h2c_tvalid;
    logic                     m_axis_h2c_tlast;
    logic [dma_bus_nbits-1:0] m_axis_h2c_tdata;
    logic                     m_axis_h2c_tready;
    logic [pbus_nbits-1:0]    rx_axis_tdata;
    logic                     rx_axis_tvalid;
    logic                     rx_axis_tlast;
    logic [15:0]              word_count;
    logic [15:0]              frame_count;

    // expected words in order, {last, data}
    logic [pbus_nbits:0] exp_q[$];

    logic [31:0] rng_state;
    int          errors;
    int          words_compared;
    int          beats_sent;
    int          frames_sent;
    int          ready_low_cycles;

    tb_clkgen u_clkgen (
        .clk_mac (clk_mac),
        .clk_axi (clk_axi),
        .rst_n   (rst_n)
    );

    h2c_rx_path #(
        .FIFO_DEPTH_LOG2 (3),
        .STATS_NBITS     (16)
    ) u_h2c_rx_path (
        .clk_mac           (clk_mac),
        .clk_axi           (clk_axi),
        .rst_n             (rst_n),
        .m_axis_h2c_tvalid (m_axis_h2c_tvalid),
        .m_axis_h2c_tlast  (m_axis_h2c_tlast),
        .m_axis_h2c_tdata  (m_axis_h2c_tdata),
        .m_axis_h2c_tready (m_axis_h2c_tready),
        .rx_axis_tdata     (rx_axis_tdata),
        .rx_axis_tvalid    (rx_axis_tvalid),
        .rx_axis_tlast     (rx_axis_tlast),
        .word_count        (word_count),
        .frame_count       (frame_count)
    );

    ////////////////////////////////////////////////////////////////////
    // random numbers and reference
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = lcg_step(rng_state);
        return rng_state;
    endfunction

    // upper half goes out first, last rides on the lower half only
    function automatic logic [pbus_nbits:0] expected_word(
        input logic [dma_bus_nbits-1:0] data,
        input logic                     last,
        input logic                     lower
    );
        if (lower) begin
            return {last, data[pbus_nbits-1:0]};
        end
        return {1'b0, data[dma_bus_nbits-1:pbus_nbits]};
    endfunction

    ////////////////////////////////////////////////////////////////////
    // dma side driver
    ////////////////////////////////////////////////////////////////////

    // entered and left 1 unit after a clk_axi edge
    task automatic send_beat(input logic last);
        logic [31:0]              hi;
        logic [31:0]              lo;
        logic [dma_bus_nbits-1:0] data;
        logic                     accepted;
        int                       waited;
        hi       = next_rand();
        lo       = next_rand();
        data     = {hi, lo};
        accepted = 1'b0;
        waited   = 0;
        m_axis_h2c_tvalid = 1'b1;
        m_axis_h2c_tlast  = last;
        m_axis_h2c_tdata  = data;
        // ready only moves on clk_axi edges, so the negedge value decides
        while (!accepted && waited < 200) begin
            @(negedge clk_axi);
            accepted = m_axis_h2c_tready;
            if (!accepted) begin
                ready_low_cycles++;
            end
            @(posedge clk_axi);
            #1;
            waited++;
        end
        if (!accepted) begin
            $display("beat was never accepted, m_axis_h2c_tready stayed low");
            errors++;
        end else begin
            beats_sent++;
            exp_q.push_back(expected_word(data, last, 1'b0));
            exp_q.push_back(expected_word(data, last, 1'b1));
        end
    endtask

    task automatic go_idle(input int cycles);
        m_axis_h2c_tvalid = 1'b0;
        m_axis_h2c_tlast  = 1'b0;
        repeat (cycles) begin
            @(posedge clk_axi);
            #1;
        end
    endtask

    // random idle cycles up to max_gap after each beat
    task automatic send_frame(input int nbeats, input int max_gap);
        for (int i = 0; i < nbeats; i++) begin
            send_beat(i == nbeats - 1);
            if (max_gap > 0) begin
                go_idle(int'(next_rand() >> 16) % (max_gap + 1));
            end
        end
        frames_sent++;
    endtask

    // stop sending, let every expected word come out, realign to clk_axi
    task automatic wait_drain();
        int waited;
        waited = 0;
        m_axis_h2c_tvalid = 1'b0;
        m_axis_h2c_tlast  = 1'b0;
        while (exp_q.size() != 0 && waited < 400) begin
            @(negedge clk_mac);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("output stalled with %0d words still expected", exp_q.size());
            errors++;
        end
        // room for a stray word and for the counters to settle
        repeat (8) @(negedge clk_mac);
        @(posedge clk_axi);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////
    // compare and watchdog
    ////////////////////////////////////////////////////////////////////

    initial begin : compare_words
        logic [pbus_nbits:0] want;
        forever begin
            @(negedge clk_mac);
            if (rst_n && rx_axis_tlast && !rx_axis_tvalid) begin
                $display("rx_axis_tlast went high without rx_axis_tvalid");
                errors++;
            end
            if (rst_n && rx_axis_tvalid) begin
                if (exp_q.size() == 0) begin
                    $display("output word %h arrived with no word expected", rx_axis_tdata);
                    errors++;
                end else begin
                    want = exp_q.pop_front();
                    if (rx_axis_tdata !== want[pbus_nbits-1:0]) begin
                        $display("FAILED rx_axis_tdata expected %h got %h",
                                 want[pbus_nbits-1:0], rx_axis_tdata);
                        errors++;
                    end
                    if (rx_axis_tlast !== want[pbus_nbits]) begin
                        $display("FAILED rx_axis_tlast expected %h got %h",
                                 want[pbus_nbits], rx_axis_tlast);
                        errors++;
                    end
                    words_compared++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge clk_mac);
        $display("run did not finish within %0d clk_mac cycles: %0d words compared, %0d errors",
                 watchdog_cycles, words_compared, errors);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////

    initial begin : run_tests
        logic [15:0] want_count;
        int          low_before;
        m_axis_h2c_tvalid = 1'b0;
        m_axis_h2c_tlast  = 1'b0;
        m_axis_h2c_tdata  = '0;
        rng_state         = 32'd70084;
        errors            = 0;
        words_compared    = 0;
        beats_sent        = 0;
        frames_sent       = 0;
        ready_low_cycles  = 0;

        // idle state once both domains are out of reset
        @(posedge rst_n);
        repeat (4) @(posedge clk_axi);
        @(negedge clk_axi);
        if (m_axis_h2c_tready !== 1'b1) begin
            $display("FAILED m_axis_h2c_tready expected 1 got %h", m_axis_h2c_tready);
            errors++;
        end
        @(negedge clk_mac);
        if (rx_axis_tvalid !== 1'b0) begin
            $display("FAILED rx_axis_tvalid expected 0 got %h", rx_axis_tvalid);
            errors++;
        end
        if (word_count !== 16'h0) begin
            $display("FAILED word_count expected 0000 got %h", word_count);
            errors++;
        end
        if (frame_count !== 16'h0) begin
            $display("FAILED frame_count expected 0000 got %h", frame_count);
            errors++;
        end
        @(posedge clk_axi);
        #1;

        // single one-beat frame
        send_frame(1, 0);
        wait_drain();
        if (words_compared != 2) begin
            $display("one-beat frame gave %0d words instead of 2", words_compared);
            errors++;
        end

        // back to back frames of 1 to 6 beats
        for (int f = 0; f < 12; f++) begin
            send_frame(1 + int'(next_rand() >> 16) % 6, 0);
        end
        wait_drain();

        // valid held high, input outruns the drain
        low_before = ready_low_cycles;
        send_frame(48, 0);
        wait_drain();
        if (ready_low_cycles == low_before) begin
            $display("m_axis_h2c_tready never fell with valid held high");
            errors++;
        end

        // random input gaps, then counters against the scoreboard
        for (int f = 0; f < 8; f++) begin
            send_frame(1 + int'(next_rand() >> 16) % 6, 3);
        end
        wait_drain();
        if (words_compared != 2 * beats_sent) begin
            $display("%0d words compared for %0d beats sent", words_compared, beats_sent);
            errors++;
        end
        want_count = 16'(words_compared);
        if (word_count !== want_count) begin
            $display("FAILED word_count expected %h got %h", want_count, word_count);
            errors++;
        end
        want_count = 16'(frames_sent);
        if (frame_count !== want_count) begin
            $display("FAILED frame_count expected %h got %h", want_count, frame_count);
            errors++;
        end

        // failed concurrent assertions in the gearbox count as errors
        errors += u_h2c_rx_path.u_gb.u_gb_assert.mac_fails
                + u_h2c_rx_path.u_gb.u_gb_assert.axi_fails;

        $display("done: %0d beats, %0d frames, %0d words compared, %0d errors",
                 beats_sent, frames_sent, words_compared, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
